// File: common/sram_bank_if.sv
// one bank's request and read data
// levels only, sampled on the rising edge of sram_clock
`timescale 1ns/1ps
`default_nettype none

interface sram_bank_if;
   import sram_pkg::*;

   logic  clock_enable;
   logic  select;
   logic  read_not_write;
   row_t  row;
   data_t write_data;
   data_t data_out;

   // decoder side
   modport request (
      output clock_enable,
      output select,
      output read_not_write,
      output row,
      output write_data
   );

   // bank side
   modport memory (
      input  clock_enable,
      input  select,
      input  read_not_write,
      input  row,
      input  write_data,
      output data_out
   );

   // read return only sees the registered word
   modport response (
      input  data_out
   );

endinterface

`default_nettype wire

// File: common/sram_pkg.sv
// banked sram package
// sizes and types shared by the decoder, the banks and the read return
`default_nettype none

package sram_pkg;

   // four banks of 256 words
   localparam int bank_count = 4;
   localparam int bank_index_width = $clog2(bank_count);
   localparam int row_width = 8;
   localparam int row_count = 1 << row_width;
   localparam int address_width = row_width + bank_index_width;
   localparam int data_width = 16;

   typedef logic [bank_index_width-1:0] bank_index_t;

   typedef logic [row_width-1:0] row_t;

   typedef logic [data_width-1:0] data_t;

   // bank number in the top bits, row in the low bits
   typedef struct packed {
      bank_index_t bank;
      row_t        row;
   } address_t;

endpackage

`default_nettype wire

// File: design/banked_sram.sv
// banked single-port sram, 1024 x 16
// four 256-word banks behind a decoder, read data returned one cycle later
`timescale 1ns/1ps
`default_nettype none

module banked_sram (
   input  logic                             sram_clock,
   input  logic                             rst,
   input  logic                             sram_clock_enable,
   input  logic                             select,
   input  logic                             read_not_write,
   input  logic [sram_pkg::address_width-1:0] address,
   input  logic [sram_pkg::data_width-1:0]    write_data,
   output logic [sram_pkg::data_width-1:0]    read_data,
   output logic                             read_valid
);
   import sram_pkg::*;

   bank_index_t bank_index;

   // one request bus per bank
   sram_bank_if bank_bus [bank_count] ();

   assign bank_index = address[address_width-1:row_width];

   sram_bank_decoder u_decoder (
      .sram_clock        (sram_clock),
      .sram_clock_enable (sram_clock_enable),
      .select            (select),
      .read_not_write    (read_not_write),
      .address           (address),
      .write_data        (write_data),
      .banks             (bank_bus)
   );

   for (genvar g = 0; g < bank_count; g++)
   begin : g_bank
      sram_bank u_bank (
         .sram_clock (sram_clock),
         .rst        (rst),
         .bus        (bank_bus[g])
      );
   end

   // picks the answering bank a cycle after the request
   sram_read_return u_read_return (
      .sram_clock        (sram_clock),
      .rst               (rst),
      .sram_clock_enable (sram_clock_enable),
      .select            (select),
      .read_not_write    (read_not_write),
      .bank_index        (bank_index),
      .banks             (bank_bus),
      .read_data         (read_data),
      .read_valid        (read_valid)
   );

endmodule

`default_nettype wire

// File: design/sram_bank_decoder.sv
// bank decoder
// splits the address and steers the request to the addressed bank
`timescale 1ns/1ps
`default_nettype none

module sram_bank_decoder (
   input  logic                sram_clock,
   input  logic                sram_clock_enable,
   input  logic                select,
   input  logic                read_not_write,
   input  sram_pkg::address_t  address,
   input  sram_pkg::data_t     write_data,
   sram_bank_if.request        banks [sram_pkg::bank_count]
);
   import sram_pkg::*;

   logic [bank_count-1:0] bank_select;

   for (genvar i = 0; i < bank_count; i++)
   begin : g_bank
      // one select per bank, gated by the top-level select
      assign bank_select[i] = select && (address.bank == bank_index_t'(i));

      // everything else goes to every bank
      assign banks[i].clock_enable   = sram_clock_enable;
      assign banks[i].select         = bank_select[i];
      assign banks[i].read_not_write = read_not_write;
      assign banks[i].row            = address.row;
      assign banks[i].write_data     = write_data;
   end

   // never two banks addressed at once
   a_one_bank_selected : assert property (
      @(posedge sram_clock) $onehot0(bank_select)
   )
   else
      $error("more than one bank selected: %b", bank_select);

endmodule

`default_nettype wire

// File: design/sram_read_return.sv
// read return
// remembers which bank was read and returns its word with a valid pulse
`timescale 1ns/1ps
`default_nettype none

module sram_read_return (
   input  logic                   sram_clock,
   input  logic                   rst,
   input  logic                   sram_clock_enable,
   input  logic                   select,
   input  logic                   read_not_write,
   input  sram_pkg::bank_index_t  bank_index,
   sram_bank_if.response          banks [sram_pkg::bank_count],
   output sram_pkg::data_t        read_data,
   output logic                   read_valid
);
   import sram_pkg::*;

   data_t       bank_data [bank_count];
   bank_index_t held_index;
   logic        read_request;

   assign read_request = sram_clock_enable && select && read_not_write;

   // registered word of each bank
   for (genvar i = 0; i < bank_count; i++)
   begin : g_data
      assign bank_data[i] = banks[i].data_out;
   end

   always_ff @(posedge sram_clock)
   begin
      if (rst)
      begin
         read_valid <= 1'b0;
         held_index <= '0;
      end
      else
      begin
         read_valid <= read_request;
         // index held until the next read, so read_data keeps its word
         if (read_request)
         begin
            held_index <= bank_index;
         end
      end
   end

   assign read_data = bank_data[held_index];

   // no read can complete in the first cycle out of reset
   a_no_valid_after_reset : assert property (
      @(posedge sram_clock) $fell(rst) |-> !read_valid
   )
   else
      $error("read_valid high in first cycle after reset");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile and run the banked sram testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f vlog.f \
   --top-module tb_banked_sram \
   -o sim_banked_sram

./obj_dir/sim_banked_sram > sim.log 2>&1

cat sim.log

if grep -q "Simulation failed" sim.log
then
   echo "run_sim: testbench reported failure"
   exit 1
fi

echo "run_sim: done"
exit 0

// File: sram_bank/sram_bank.sv
// single-port synchronous sram bank
// writes on a selected edge, registers the word on a selected read
`timescale 1ns/1ps
`default_nettype none

module sram_bank (
   input  logic         sram_clock,
   input  logic         rst,
   sram_bank_if.memory  bus
);
   import sram_pkg::*;

   data_t ram [row_count];

   logic  access;
   logic  do_write;
   logic  do_read;

   assign access   = bus.clock_enable && bus.select;
   assign do_write = access && !bus.read_not_write;
   assign do_read  = access && bus.read_not_write;

   // array contents survive reset
   always_ff @(posedge sram_clock)
   begin
      if (do_write)
      begin
         ram[bus.row] <= bus.write_data;
      end
   end

   // registered read port
   always_ff @(posedge sram_clock)
   begin
      if (rst)
      begin
         bus.data_out <= '0;
      end
      else if (do_read)
      begin
         bus.data_out <= ram[bus.row];
      end
   end

   // data_out only moves after a selected read or a reset
   a_data_out_stable : assert property (
      @(posedge sram_clock)
      $changed(bus.data_out) |-> ($past(rst) || $past(do_read))
   )
   else
      $error("bank data_out changed without a read: %h", bus.data_out);

endmodule

`default_nettype wire

// File: tb/tb_banked_sram.sv
// testbench for the banked sram
// directed phases and random traffic checked against a word-level model
`timescale 1ns/1ps
`default_nettype none

module tb_banked_sram;
   import sram_pkg::*;

   localparam int random_cycles   = 1000;
   localparam int watchdog_cycles = random_cycles + 300;

   logic                     sram_clock;
   logic                     rst;
   logic                     sram_clock_enable;
   logic                     select;
   logic                     read_not_write;
   logic [address_width-1:0] address;
   logic [data_width-1:0]    write_data;
   logic [data_width-1:0]    read_data;
   logic                     read_valid;

   // reference model
   data_t                    model_mem [logic [address_width-1:0]];
   data_t                    exp_data;
   logic                     exp_valid;
   logic [address_width-1:0] written_q [$];
   int                       error_count;
   int                       read_count;

   tb_clock_gen #(.period_ns(20), .reset_cycles(8)) clock_gen0 (
      .sram_clock (sram_clock),
      .rst        (rst)
   );

   banked_sram dut0 (
      .sram_clock        (sram_clock),
      .rst               (rst),
      .sram_clock_enable (sram_clock_enable),
      .select            (select),
      .read_not_write    (read_not_write),
      .address           (address),
      .write_data        (write_data),
      .read_data         (read_data),
      .read_valid        (read_valid)
   );

   // top-level rule with one cycle of read latency
   always @(posedge sram_clock)
   begin
      if (rst)
      begin
         exp_valid <= 1'b0;
         exp_data  <= '0;
      end
      else
      begin
         exp_valid <= sram_clock_enable && select && read_not_write;
         if (sram_clock_enable && select && read_not_write)
         begin
            read_count++;
            if (model_mem.exists(address))
            begin
               exp_data <= model_mem[address];
            end
            else
            begin
               error_count++;
               $display("read issued to address %h, which was never written", address);
            end
         end
         else if (sram_clock_enable && select)
         begin
            model_mem[address] = write_data;
         end
      end
   end

   // checks at mid-cycle
   a_read_valid : assert property (
      @(negedge sram_clock) disable iff (rst) read_valid == exp_valid
   )
   else
   begin
      error_count++;
      $display("[ERROR] %0t read_valid expected %b actual %b", $time, exp_valid, read_valid);
   end

   a_read_data : assert property (
      @(negedge sram_clock) disable iff (rst) read_data == exp_data
   )
   else
   begin
      error_count++;
      $display("[ERROR] %0t read_data expected %h actual %h", $time, exp_data, read_data);
   end

   function automatic logic [address_width-1:0] make_address(input int bank, input int row);
      logic [31:0] b;
      logic [31:0] r;
      b = bank;
      r = row;
      return {b[bank_index_width-1:0], r[row_width-1:0]};
   endfunction

   // request levels held for one cycle
   task automatic drive_request(input logic ce, input logic sel, input logic rnw,
                                input logic [address_width-1:0] addr, input data_t data);
      @(posedge sram_clock);
      sram_clock_enable <= ce;
      select            <= sel;
      read_not_write    <= rnw;
      address           <= addr;
      write_data        <= data;
   endtask

   task automatic write_word(input logic [address_width-1:0] addr, input data_t data);
      written_q.push_back(addr);
      drive_request(1'b1, 1'b1, 1'b0, addr, data);
   endtask

   task automatic read_word(input logic [address_width-1:0] addr);
      drive_request(1'b1, 1'b1, 1'b1, addr, 16'hdead);
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++)
      begin
         drive_request(1'b0, 1'b0, 1'b0, '0, '0);
      end
   endtask

   task automatic random_traffic(input int cycles);
      logic [31:0]              rnd;
      logic                     ce;
      logic                     sel;
      logic                     rnw;
      logic [address_width-1:0] addr;
      int                       pick;
      for (int i = 0; i < cycles; i++)
      begin
         rnd = $urandom;
         ce  = (rnd[2:0] != 3'd0);
         sel = (rnd[5:3] != 3'd0);
         rnw = rnd[6];
         if (rnw)
         begin
            // reads only where the model knows the word
            pick = $urandom_range(written_q.size() - 1, 0);
            addr = written_q[pick];
         end
         else
         begin
            addr = address_width'($urandom);
            if (ce && sel)
            begin
               written_q.push_back(addr);
            end
         end
         drive_request(ce, sel, rnw, addr, rnd[31:16]);
      end
   endtask

   initial
   begin
      void'($urandom(32'h6937));
      error_count       = 0;
      read_count        = 0;
      sram_clock_enable = 1'b0;
      select            = 1'b0;
      read_not_write    = 1'b0;
      address           = '0;
      write_data        = '0;
      @(negedge rst);

      // outputs sit at zero out of reset
      idle_cycles(3);

      // fill a few rows in every bank, then read them back
      for (int b = 0; b < bank_count; b++)
      begin
         for (int k = 0; k < 4; k++)
         begin
            write_word(make_address(b, k * 37 + b), data_t'(16'ha000 + b * 256 + k));
         end
      end
      for (int b = 0; b < bank_count; b++)
      begin
         for (int k = 0; k < 4; k++)
         begin
            read_word(make_address(b, k * 37 + b));
         end
      end

      // blocked by clock enable or by select
      drive_request(1'b0, 1'b1, 1'b0, make_address(1, 37 + 1), 16'h5555);
      drive_request(1'b1, 1'b0, 1'b0, make_address(1, 37 + 1), 16'h6666);
      drive_request(1'b0, 1'b1, 1'b1, make_address(2, 2), '0);
      drive_request(1'b1, 1'b0, 1'b1, make_address(2, 2), '0);
      read_word(make_address(1, 37 + 1));
      idle_cycles(2);

      // back-to-back reads rotating through the banks
      for (int i = 0; i < 12; i++)
      begin
         read_word(make_address(i % bank_count, (i / bank_count) * 37 + i % bank_count));
      end

      // read data must hold through idle cycles and writes
      read_word(make_address(3, 3));
      idle_cycles(3);
      write_word(make_address(3, 3), 16'h1234);
      write_word(make_address(0, 74), 16'h4321);
      idle_cycles(2);
      read_word(make_address(3, 3));
      idle_cycles(2);

      random_traffic(random_cycles);
      idle_cycles(3);

      $display("errors: %0d, reads checked: %0d", error_count, read_count);
      if (error_count == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge sram_clock);
      $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// testbench clock and reset
// free-running sram_clock, rst held high for the first few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int period_ns    = 20,
   parameter int reset_cycles = 8
) (
   output logic sram_clock,
   output logic rst
);

   initial
   begin
      sram_clock = 1'b0;
      rst        = 1'b1;
      repeat (reset_cycles) @(posedge sram_clock);
      rst <= 1'b0;
   end

   always #(period_ns / 2) sram_clock = ~sram_clock;

endmodule

`default_nettype wire

// File: vlog.f
common/sram_pkg.sv
common/sram_bank_if.sv
design/sram_bank_decoder.sv
sram_bank/sram_bank.sv
design/sram_read_return.sv
design/banked_sram.sv
tb/tb_clock_gen.sv
tb/tb_banked_sram.sv
